// File: all.f
logic/scaler_pkg.sv
logic/display_timing.sv
logic/host_write_port.sv
logic/fb_line_scaler.sv
logic/palette_paint.sv
logic/scaled_display_top.sv
test/tb_scaled_display.sv

// File: logic/display_timing.sv
// ********************
// display timing
// raster counters with de, frame and line load pulses
// ********************

module display_timing (
    input  logic                          clk_pix,
    input  logic                          rst,
    output logic [scaler_pkg::CORDW-1:0]  sx,         // horizontal position
    output logic [scaler_pkg::CORDW-1:0]  sy,         // vertical position
    output logic                          de,         // active area
    output logic                          frame,      // start of frame
    output logic                          line_load   // start of h blanking
);

    // raster counters
    always_ff @(posedge clk_pix) begin
        if (rst) begin
            sx <= '0;
            sy <= '0;
        end else if (sx == scaler_pkg::H_TOTAL - 1'b1) begin  // end of line
            sx <= '0;
            if (sy == scaler_pkg::V_TOTAL - 1'b1) begin
                sy <= '0;  // wrap to top
            end else begin
                sy <= sy + 1'b1;
            end
        end else begin
            sx <= sx + 1'b1;
        end
    end

    // decoded straight from the counters, same cycle as sx/sy
    always_comb begin
        de        = (sx < scaler_pkg::H_ACTIVE) && (sy < scaler_pkg::V_ACTIVE);
        frame     = (sx == '0) && (sy == '0);
        line_load = (sx == scaler_pkg::H_ACTIVE);  // every line, scaler decides use
    end

    // line never runs past its last clock
    a_sx_range: assert property (
        @(posedge clk_pix) disable iff (rst)
        sx < scaler_pkg::H_TOTAL
    );

endmodule

// File: logic/fb_line_scaler.sv
// ********************
// framebuffer line scaler
// fb memory, line fetch into the linebuffer, x and y replication
// ********************

module fb_line_scaler #(
    parameter int FB_WIDTH  = 16,  // fb pixels per line
    parameter int FB_HEIGHT = 12,  // fb lines
    parameter int SCALE     = 4    // screen pixels per fb pixel, both axes
) (
    input  logic                             clk_pix,
    input  logic                             rst,
    input  logic [scaler_pkg::CORDW-1:0]     sx,
    input  logic [scaler_pkg::CORDW-1:0]     sy,
    input  logic                             line_load,
    input  logic                             fb_we,
    input  logic [scaler_pkg::FB_ADDRW-1:0]  fb_waddr,
    input  logic [scaler_pkg::CIDXW-1:0]     fb_wcidx,
    output logic [scaler_pkg::CIDXW-1:0]     lb_cidx   // index for sx of last cycle
);

    localparam int FB_PIXELS = FB_WIDTH * FB_HEIGHT;
    localparam int LBW       = $clog2(FB_WIDTH);  // linebuffer address width

    if (FB_WIDTH * SCALE != scaler_pkg::H_ACTIVE ||
        FB_HEIGHT * SCALE != scaler_pkg::V_ACTIVE) begin : g_size_check
        $error("framebuffer size times scale does not match the active area");
    end

    logic [scaler_pkg::CIDXW-1:0]    fb_mem [FB_PIXELS];
    logic [scaler_pkg::CIDXW-1:0]    lb_mem [FB_WIDTH];
    logic [scaler_pkg::CORDW-1:0]    next_sy;     // line after this one
    logic                            need_fetch;  // next line starts a new fb row
    logic [scaler_pkg::FB_ADDRW-1:0] row_base;
    logic                            fetch_act;
    logic [LBW-1:0]                  fetch_cnt;   // fb column being read
    logic [scaler_pkg::FB_ADDRW-1:0] fb_raddr;
    logic [scaler_pkg::CIDXW-1:0]    fb_rdata;
    logic                            lb_we;       // one cycle behind the read
    logic [LBW-1:0]                  lb_waddr;

    // which fb row the next display line needs
    always_comb begin
        next_sy    = (sy == scaler_pkg::V_TOTAL - 1'b1) ? '0 : sy + 1'b1;  // last line refetches row 0
        need_fetch = (next_sy < scaler_pkg::V_ACTIVE) && (next_sy % SCALE == 0);
        row_base   = scaler_pkg::FB_ADDRW'((next_sy / SCALE) * FB_WIDTH);
    end

    // host writes
    always_ff @(posedge clk_pix) begin
        if (fb_we) fb_mem[fb_waddr] <= fb_wcidx;
    end

    // registered read, latency 1
    always_ff @(posedge clk_pix) begin
        fb_rdata <= fb_mem[fb_raddr];
    end

    // fetch control, 16 reads then the trailing lb write
    always_ff @(posedge clk_pix) begin
        if (rst) begin
            fetch_act <= 1'b0;
            lb_we     <= 1'b0;
        end else begin
            lb_we <= fetch_act;
            if (line_load && need_fetch) begin
                fetch_act <= 1'b1;
            end else if (fetch_act && fetch_cnt == LBW'(FB_WIDTH - 1)) begin
                fetch_act <= 1'b0;  // last column issued
            end
        end
    end

    // fetch address walk
    always_ff @(posedge clk_pix) begin
        lb_waddr <= fetch_cnt;
        if (line_load && need_fetch) begin
            fb_raddr  <= row_base;
            fetch_cnt <= '0;
        end else if (fetch_act) begin
            fb_raddr  <= fb_raddr + 1'b1;
            fetch_cnt <= fetch_cnt + 1'b1;
        end
    end

    // linebuffer fill, only in h blanking
    always_ff @(posedge clk_pix) begin
        if (lb_we) lb_mem[lb_waddr] <= fb_rdata;
    end

    // horizontal replication, each entry read for SCALE clocks
    always_ff @(posedge clk_pix) begin
        lb_cidx <= lb_mem[LBW'(sx / SCALE)];
    end

    // fill never overlaps the visible part of a line
    a_fill_in_blank: assert property (
        @(posedge clk_pix) disable iff (rst)
        lb_we |-> sx >= scaler_pkg::H_ACTIVE
    );

endmodule

// File: logic/host_write_port.sv
// ********************
// host write port
// four-phase req/ack slave, one fb or palette write per word
// ********************

module host_write_port (
    input  logic                             clk_pix,
    input  logic                             rst,
    input  logic                             wr_req,
    input  logic                             wr_target,  // 0 fb, 1 palette
    input  scaler_pkg::host_word_u           wr_word,
    output logic                             wr_ack,
    output logic                             fb_we,
    output logic [scaler_pkg::FB_ADDRW-1:0]  fb_waddr,
    output logic [scaler_pkg::CIDXW-1:0]     fb_wcidx,
    output logic                             pal_we,
    output logic [scaler_pkg::CIDXW-1:0]     pal_widx,
    output logic [scaler_pkg::COLRW-1:0]     pal_wcolr
);

    typedef enum logic [1:0] {
        IDLE,
        WRITE,
        ACK_HELD
    } state_t;

    state_t                 state;
    scaler_pkg::host_word_u word_q;    // held for the whole handshake
    logic                   target_q;

    // control
    always_ff @(posedge clk_pix) begin
        if (rst) begin
            state  <= IDLE;
            wr_ack <= 1'b0;
            fb_we  <= 1'b0;
            pal_we <= 1'b0;
        end else begin
            fb_we  <= 1'b0;  // single cycle pulses
            pal_we <= 1'b0;
            case (state)
                IDLE: if (wr_req) state <= WRITE;  // word captured below
                WRITE: begin
                    fb_we  <= !target_q;
                    pal_we <= target_q;
                    state  <= ACK_HELD;
                end
                ACK_HELD: begin
                    wr_ack <= wr_req;  // rises with the write, drops after req
                    if (wr_ack && !wr_req) state <= IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end

    // payload capture
    always_ff @(posedge clk_pix) begin
        if (state == IDLE && wr_req) begin
            word_q   <= wr_word;
            target_q <= wr_target;
        end
    end

    // both views of the held word
    assign fb_waddr  = word_q.fb.addr;
    assign fb_wcidx  = word_q.fb.cidx;
    assign pal_widx  = word_q.pal.idx;
    assign pal_wcolr = word_q.pal.colr;

    // ack only rises while req is still up
    a_ack_needs_req: assert property (
        @(posedge clk_pix) disable iff (rst)
        $rose(wr_ack) |-> wr_req
    );

    // no new request until the last ack is gone
    a_req_after_ack: assert property (
        @(posedge clk_pix) disable iff (rst)
        $rose(wr_req) |-> !wr_ack
    );

endmodule

// File: logic/palette_paint.sv
// ********************
// palette painter
// palette lookup, position alignment, blanking, output regs
// ********************

module palette_paint (
    input  logic                                 clk_pix,
    input  logic                                 rst,
    input  logic [scaler_pkg::CORDW-1:0]         sx,
    input  logic [scaler_pkg::CORDW-1:0]         sy,
    input  logic                                 de,
    input  logic                                 frame,
    input  logic [scaler_pkg::CIDXW-1:0]         lb_cidx,  // one cycle behind sx
    input  logic                                 pal_we,
    input  logic [scaler_pkg::CIDXW-1:0]         pal_widx,
    input  logic [scaler_pkg::COLRW-1:0]         pal_wcolr,
    output logic [scaler_pkg::CORDW-1:0]         out_sx,
    output logic [scaler_pkg::CORDW-1:0]         out_sy,
    output logic                                 out_de,
    output logic                                 out_frame,
    output logic [2*scaler_pkg::CHANW-1:0]       out_r,
    output logic [2*scaler_pkg::CHANW-1:0]       out_g,
    output logic [2*scaler_pkg::CHANW-1:0]       out_b
);

    logic [scaler_pkg::COLRW-1:0] pal_mem [2**scaler_pkg::CIDXW];
    logic [scaler_pkg::COLRW-1:0] pal_colr;          // two cycles behind sx
    logic [scaler_pkg::CORDW-1:0] sx_d1, sx_d2;
    logic [scaler_pkg::CORDW-1:0] sy_d1, sy_d2;
    logic                         de_d1, de_d2;
    logic                         frame_d1, frame_d2;
    logic [scaler_pkg::CHANW-1:0] paint_r, paint_g, paint_b;

    always_ff @(posedge clk_pix) begin
        if (pal_we) pal_mem[pal_widx] <= pal_wcolr;
    end

    always_ff @(posedge clk_pix) begin
        pal_colr <= pal_mem[lb_cidx];  // lb read + this = 2 cycles
    end

    // position delay to meet the palette output
    always_ff @(posedge clk_pix) begin
        sx_d1 <= sx;
        sx_d2 <= sx_d1;
        sy_d1 <= sy;
        sy_d2 <= sy_d1;
    end

    always_ff @(posedge clk_pix) begin
        if (rst) begin
            {de_d1, de_d2}       <= '0;
            {frame_d1, frame_d2} <= '0;
        end else begin
            de_d1    <= de;
            de_d2    <= de_d1;
            frame_d1 <= frame;
            frame_d2 <= frame_d1;
        end
    end

    // black outside the active area
    always_comb begin
        {paint_r, paint_g, paint_b} = de_d2 ? pal_colr : '0;
    end

    // output regs, total latency 3
    always_ff @(posedge clk_pix) begin
        if (rst) begin
            out_de    <= 1'b0;
            out_frame <= 1'b0;
            out_r     <= '0;
            out_g     <= '0;
            out_b     <= '0;
        end else begin
            out_de    <= de_d2;
            out_frame <= frame_d2;
            out_r     <= {2{paint_r}};  // 4 to 8 bits, f -> ff
            out_g     <= {2{paint_g}};
            out_b     <= {2{paint_b}};
        end
    end

    always_ff @(posedge clk_pix) begin
        out_sx <= sx_d2;
        out_sy <= sy_d2;
    end

endmodule

// File: logic/scaled_display_top.sv
// ********************
// scaled display top
// timing, host port, line scaler and palette painter
// ********************

module scaled_display_top #(
    parameter int FB_WIDTH  = 16,
    parameter int FB_HEIGHT = 12,
    parameter int SCALE     = 4
) (
    input  logic                                 clk_pix,
    input  logic                                 rst,
    input  logic                                 wr_req,
    input  logic                                 wr_target,
    input  scaler_pkg::host_word_u               wr_word,
    output logic                                 wr_ack,
    output logic [scaler_pkg::CORDW-1:0]         out_sx,
    output logic [scaler_pkg::CORDW-1:0]         out_sy,
    output logic                                 out_de,
    output logic                                 out_frame,
    output logic [2*scaler_pkg::CHANW-1:0]       out_r,
    output logic [2*scaler_pkg::CHANW-1:0]       out_g,
    output logic [2*scaler_pkg::CHANW-1:0]       out_b
);

    // raster
    logic [scaler_pkg::CORDW-1:0]    sx, sy;
    logic                            de, frame, line_load;
    // host writes
    logic                            fb_we, pal_we;
    logic [scaler_pkg::FB_ADDRW-1:0] fb_waddr;
    logic [scaler_pkg::CIDXW-1:0]    fb_wcidx, pal_widx;
    logic [scaler_pkg::COLRW-1:0]    pal_wcolr;
    // scaled index
    logic [scaler_pkg::CIDXW-1:0]    lb_cidx;

    display_timing u_timing (
        .clk_pix, .rst, .sx, .sy, .de, .frame, .line_load
    );

    host_write_port u_host (
        .clk_pix, .rst, .wr_req, .wr_target, .wr_word, .wr_ack,
        .fb_we, .fb_waddr, .fb_wcidx, .pal_we, .pal_widx, .pal_wcolr
    );

    fb_line_scaler #(
        .FB_WIDTH(FB_WIDTH),
        .FB_HEIGHT(FB_HEIGHT),
        .SCALE(SCALE)
    ) u_scaler (
        .clk_pix, .rst, .sx, .sy, .line_load,
        .fb_we, .fb_waddr, .fb_wcidx, .lb_cidx
    );

    palette_paint u_paint (
        .clk_pix, .rst, .sx, .sy, .de, .frame, .lb_cidx,
        .pal_we, .pal_widx, .pal_wcolr,
        .out_sx, .out_sy, .out_de, .out_frame, .out_r, .out_g, .out_b
    );

endmodule

// File: logic/scaler_pkg.sv
// ********************
// scaler package
// raster constants, colour widths and the host write word
// ********************

package scaler_pkg;

    // colour
    localparam int CHANW = 4;          // bits per colour channel
    localparam int COLRW = 3 * CHANW;  // rgb, three channels
    localparam int CIDXW = 4;          // colour index, 16 palette entries

    // screen coordinates
    localparam int CORDW = 7;  // unsigned, covers H_TOTAL

    // raster, sized to the coordinate width
    localparam logic [CORDW-1:0] H_ACTIVE = 7'd64;  // 16 fb pixels x4
    localparam logic [CORDW-1:0] H_TOTAL  = 7'd88;  // 24 blanking clocks for the line fetch
    localparam logic [CORDW-1:0] V_ACTIVE = 7'd48;  // 12 fb lines x4
    localparam logic [CORDW-1:0] V_TOTAL  = 7'd52;

    // framebuffer addressing
    localparam int FB_ADDRW = 8;  // 192 pixels fit

    // host write word, fb or palette view picked by wr_target
    typedef union packed {
        struct packed {
            logic [FB_ADDRW-1:0] addr;   // row*width + col
            logic [3:0]          spare;  // ignored
            logic [CIDXW-1:0]    cidx;
        } fb;
        struct packed {
            logic [CIDXW-1:0] idx;   // palette entry
            logic [COLRW-1:0] colr;  // {r, g, b}
        } pal;
    } host_word_u;

endpackage

// File: run_sim.sh
#!/bin/sh
# build and run the scaled display testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_scaled_display -f all.f -o sim_tb
status=$?
if [ $status -ne 0 ]; then
    echo "build failed with status $status"
    exit $status
fi

./obj_dir/sim_tb
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed with status $status"
    exit $status
fi

echo "simulation passed"
exit 0

// File: test/tb_scaled_display.sv
// ********************
// scaled display testbench
// file driven host writes, full frame check against a model
// ********************

module tb_scaled_display;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int FB_WIDTH     = 16;
    localparam int FB_HEIGHT    = 12;
    localparam int SCALE        = 4;
    localparam int FB_PIXELS    = FB_WIDTH * FB_HEIGHT;
    localparam int PAL_SIZE     = 16;
    localparam int H_TOTAL      = 88;   // clocks per line
    localparam int V_TOTAL      = 52;   // lines per frame
    localparam int FRAME_CYC    = H_TOTAL * V_TOTAL;
    localparam int ACK_WAIT     = 8;        // cycles allowed for each ack edge
    localparam int WRITE_BUDGET = 8;        // timeout share per handshake
    localparam int TEST_WORDS   = 256;

    logic        clk_pix, rst;
    logic        wr_req, wr_target, wr_ack;
    logic [15:0] wr_word;
    logic [6:0]  out_sx, out_sy;
    logic        out_de, out_frame;
    logic [7:0]  out_r, out_g, out_b;

    logic [31:0] test_mem [TEST_WORDS];  // raw hex words from the test file
    logic        wr_tgt_q [$];
    logic [15:0] wr_word_q [$];
    int          probe_x_q [$];
    int          probe_y_q [$];
    logic [23:0] probe_rgb_q [$];
    bit          probe_seen [$];
    logic [3:0]  fb_model [FB_PIXELS];  // own copy of every write
    logic [11:0] pal_model [PAL_SIZE];
    int          cycle_count = 0;
    int          cycle_limit = 32'h7fff_ffff;  // real limit set once the file is read

    scaled_display_top #(
        .FB_WIDTH(FB_WIDTH),
        .FB_HEIGHT(FB_HEIGHT),
        .SCALE(SCALE)
    ) u_dut (
        .clk_pix, .rst, .wr_req, .wr_target, .wr_word, .wr_ack,
        .out_sx, .out_sy, .out_de, .out_frame, .out_r, .out_g, .out_b
    );

    initial begin
        clk_pix = 1'b0;
        forever #10 clk_pix = ~clk_pix;  // 50 MHz
    end

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("Errors found");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        if (got !== want)
            stop_with_failure($sformatf("mismatch at time %0t: %s is %h, expected %h",
                                        $time, name, got, want));
    endtask

    // screen position -> fb pixel -> palette -> doubled channels
    function automatic logic [23:0] expected_rgb(input int x, input int y);
        logic [11:0] c;
        c = pal_model[fb_model[(y / SCALE) * FB_WIDTH + x / SCALE]];
        return {c[11:8], c[11:8], c[7:4], c[7:4], c[3:0], c[3:0]};
    endfunction

    // record kinds: 1 write, 2 probe, 0 end
    task automatic load_tests();
        int i;
        $readmemh("test/tests_scaled_display.txt", test_mem);
        i = 0;
        while (i < TEST_WORDS - 4 && test_mem[i] != 32'd0) begin
            if (test_mem[i] == 32'd1) begin
                wr_tgt_q.push_back(test_mem[i+1][0]);
                wr_word_q.push_back(test_mem[i+2][15:0]);
                i += 3;
            end else if (test_mem[i] == 32'd2) begin
                probe_x_q.push_back(test_mem[i+1]);
                probe_y_q.push_back(test_mem[i+2]);
                probe_rgb_q.push_back(test_mem[i+3][23:0]);
                probe_seen.push_back(1'b0);
                i += 4;
            end else begin
                stop_with_failure(
                    $sformatf("unknown record kind at word %0d of the test file", i));
            end
        end
    endtask

    // one four-phase handshake, then a few idle clocks
    task automatic host_write(input logic tgt, input logic [15:0] word);
        int waited;
        int idle;
        @(posedge clk_pix);
        wr_req    <= 1'b1;
        wr_target <= tgt;
        wr_word   <= word;
        @(negedge clk_pix);
        check_value("wr_ack", 32'(wr_ack), 0);  // last ack must be gone
        waited = 0;
        while (!wr_ack && waited < ACK_WAIT) begin
            @(negedge clk_pix);
            waited++;
        end
        if (!wr_ack) stop_with_failure("wr_ack did not rise within 8 cycles of wr_req");
        @(posedge clk_pix);
        wr_req <= 1'b0;
        @(negedge clk_pix);
        check_value("wr_ack", 32'(wr_ack), 1);  // held until req is seen low
        waited = 0;
        while (wr_ack && waited < ACK_WAIT) begin
            @(negedge clk_pix);
            waited++;
        end
        if (wr_ack) stop_with_failure("wr_ack stayed high after wr_req dropped");
        if (tgt) pal_model[word[15:12]] = word[11:0];  // {idx, rgb}
        else fb_model[word[15:8]] = word[3:0];          // {addr, spare, cidx}
        idle = $urandom % 4;
        repeat (idle) @(posedge clk_pix);
    endtask

    // one whole frame, every clock, sampled at negedge
    task automatic check_frame();
        logic [23:0] rgb;
        int p;
        int x;
        int y;
        do @(negedge clk_pix); while (!out_de);  // next pulse then starts a fresh frame
        do @(negedge clk_pix); while (!out_frame);
        for (int i = 0; i < FRAME_CYC; i++) begin
            if (i > 0) begin
                @(negedge clk_pix);
                check_value("out_frame", 32'(out_frame), 0);
            end
            x = i % H_TOTAL;  // raster walk from the frame pulse
            y = i / H_TOTAL;
            check_value("out_sx", 32'(out_sx), 32'(x));
            check_value("out_sy", 32'(out_sy), 32'(y));
            rgb = {out_r, out_g, out_b};
            check_value("out_de", 32'(out_de),
                        32'(x < FB_WIDTH * SCALE && y < FB_HEIGHT * SCALE));
            if (!out_de) begin
                check_value("out_rgb", 32'(rgb), 0);  // blanked
            end else begin
                check_value("out_rgb", 32'(rgb), 32'(expected_rgb(x, y)));
                for (p = 0; p < probe_x_q.size(); p++) begin
                    if (x == probe_x_q[p] && y == probe_y_q[p]) begin
                        check_value("probe_rgb", 32'(rgb), 32'(probe_rgb_q[p]));
                        probe_seen[p] = 1'b1;
                    end
                end
            end
        end
        @(negedge clk_pix);
        check_value("out_frame", 32'(out_frame), 1);  // exactly one frame later
        for (p = 0; p < probe_x_q.size(); p++)
            if (!probe_seen[p])
                stop_with_failure($sformatf("probe at x %0d y %0d never showed up",
                                            probe_x_q[p], probe_y_q[p]));
    endtask

    always @(posedge clk_pix) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit)
            stop_with_failure($sformatf("timeout after %0d cycles, run did not finish",
                                        cycle_limit));
    end

    initial begin
        logic [7:0] addr;
        logic [3:0] idx;
        void'($urandom(89923));
        rst       = 1'b1;
        wr_req    = 1'b0;
        wr_target = 1'b0;
        wr_word   = '0;
        load_tests();
        cycle_limit = WRITE_BUDGET * (wr_tgt_q.size() + FB_PIXELS + PAL_SIZE) + 3 * FRAME_CYC;
        repeat (4) @(posedge clk_pix);
        rst <= 1'b0;
        for (int a = 0; a < FB_PIXELS; a++) begin  // known fb contents
            addr = 8'(a);
            host_write(1'b0, {addr, 4'h0, addr[7:4] ^ addr[3:0]});
        end
        for (int i = 0; i < PAL_SIZE; i++) begin
            idx = 4'(i);
            host_write(1'b1, {idx, idx, 4'hf - idx, idx ^ 4'ha});
        end
        for (int w = 0; w < wr_tgt_q.size(); w++)
            host_write(wr_tgt_q[w], wr_word_q[w]);
        for (int p = 0; p < probe_x_q.size(); p++)  // file values agree with the model
            check_value("probe_model", 32'(expected_rgb(probe_x_q[p], probe_y_q[p])),
                        32'(probe_rgb_q[p]));
        check_frame();
        $display("No errors");
        $finish;
    end

endmodule

// File: test/tests_scaled_display.txt
// kind 1 write: target (0 fb, 1 palette), word {addr, 0, cidx} or {idx, rgb}
// kind 2 probe: x, y, expected 24 bit rgb; kind 0 ends the list
1 1 3f80
1 1 90af
1 1 c5e1
1 0 2503
1 0 2609
1 0 bf03
1 0 0009
1 0 7a0c
2 14 08 ff8800
2 17 08 ff8800
2 14 0b ff8800
2 17 0b ff8800
2 13 08 6699cc
2 18 08 00aaff
2 14 0c 6699cc
2 14 07 44bbee
2 3f 2f ff8800
2 3b 2f 55aaff
2 00 00 00aaff
2 04 00 11eebb
2 28 1c 55ee11
2 27 1c ee1144
0
